// File: Bender.yml
package:
  name: mecobo

sources:
  - design/mecobo_cmd_pkg.sv
  - design/mecobo_sample_pkg.sv
  - design/sync_fifo.sv
  - design/host_bridge.sv
  - design/scheduler.sv
  - design/pin_control.sv
  - design/sample_collector.sv
  - design/mecobo_core.sv
  - target: test
    files:
      - testbench/mecobo_tb.sv

// File: design/host_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module host_bridge
  import mecobo_cmd_pkg::*, mecobo_sample_pkg::*;
(
  input  wire         sys_clk,
  input  wire         mecobo_reset,
  // APB slave
  input  wire  [7:0]  paddr,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  wire  [31:0] current_time,
  // command FIFO write side
  output logic        cmd_push,
  output cmd_t        cmd_din,
  input  wire         cmd_full,
  // sample FIFO read side
  output logic        sample_pop,
  input  sample_t     sample_dout,
  input  wire         sample_empty,
  input  wire  [7:0]  sample_count,
  output logic        irq
);

  localparam logic [7:0] addr_start  = 8'h00;
  localparam logic [7:0] addr_cmd    = 8'h04;
  localparam logic [7:0] addr_data   = 8'h08;
  localparam logic [7:0] addr_status = 8'h0C;
  localparam logic [7:0] addr_sample = 8'h10;
  localparam logic [7:0] addr_time   = 8'h14;

  logic [31:0] start_stage;
  logic [15:0] addr_stage;
  logic        access;
  logic        wr_data;
  logic        rd_sample;

  assign access    = psel && penable;
  assign wr_data   = access && pwrite && (paddr == addr_data);
  assign rd_sample = access && !pwrite && (paddr == addr_sample);

  // staged fields, the data write completes the command
  always_ff @(posedge sys_clk) begin
    if (access && pwrite && paddr == addr_start) begin
      start_stage <= pwdata;
    end
    if (access && pwrite && paddr == addr_cmd) begin
      addr_stage <= pwdata[15:0];
    end
  end

  assign cmd_din    = '{start_time: start_stage, addr: addr_stage, data: pwdata};
  assign cmd_push   = wr_data && !cmd_full;
  assign sample_pop = rd_sample && !sample_empty;

  assign pready  = 1'b1;
  // overflow and underflow only flag the transfer
  assign pslverr = (wr_data && cmd_full) || (rd_sample && sample_empty);
  assign irq     = !sample_empty;

  always_comb begin
    prdata = 32'd0;
    if (access && !pwrite) begin
      case (paddr)
        addr_status: prdata = {16'd0, sample_count, 6'd0, sample_empty, cmd_full};
        addr_sample: prdata = sample_empty ? 32'd0 : sample_dout;
        addr_time:   prdata = current_time;
        default:     prdata = 32'd0;
      endcase
    end
  end

  // access phase must follow a setup phase
  a_apb_phase: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    penable |-> psel && $past(psel && !penable))
    else $error("penable without a preceding setup cycle");

endmodule

`default_nettype wire

// File: design/mecobo_cmd_pkg.sv
`default_nettype none

package mecobo_cmd_pkg;

  // one time-stamped command as queued by the host
  typedef struct packed {
    logic [31:0] start_time;
    logic [15:0] addr;
    logic [31:0] data;
  } cmd_t;

  // shared command bus, write only, en lasts one cycle
  typedef struct packed {
    logic        en;
    logic [15:0] addr;
    logic [31:0] data;
  } cmd_bus_t;

  // upper address byte of the sample collector
  localparam logic [7:0] collector_unit = 8'hF0;

  // pin controller registers
  localparam logic [7:0] reg_mode        = 8'd0;
  localparam logic [7:0] reg_half_period = 8'd1;
  localparam logic [7:0] reg_level       = 8'd2;

  // sample collector registers
  localparam logic [7:0] reg_channel_mask  = 8'd0;
  localparam logic [7:0] reg_sample_period = 8'd1;

endpackage

`default_nettype wire

// File: design/mecobo_core.sv
`timescale 1ns/1ps
`default_nettype none

module mecobo_core
  import mecobo_cmd_pkg::*, mecobo_sample_pkg::*;
#(
  parameter int NUM_PINS   = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  wire                 sys_clk,
  input  wire                 mecobo_reset,
  input  wire  [7:0]          paddr,
  input  wire                 psel,
  input  wire                 penable,
  input  wire                 pwrite,
  input  wire  [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                irq,
  output logic [NUM_PINS-1:0] pins
);

  logic [31:0] current_time;
  logic        cmd_push;
  cmd_t        cmd_din;
  cmd_t        cmd_dout;
  logic        cmd_empty;
  logic        cmd_full;
  logic        cmd_pop;
  cmd_bus_t    cmd_bus;
  logic        sample_push;
  sample_t     sample_din;
  sample_t     sample_dout;
  logic        sample_pop;
  logic        sample_empty;
  logic        sample_full;
  logic [7:0]  sample_count;

  host_bridge host_bridge_inst (
    .sys_clk, .mecobo_reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .current_time, .cmd_push, .cmd_din, .cmd_full,
    .sample_pop, .sample_dout, .sample_empty, .sample_count, .irq
  );

  sync_fifo #(.payload_t(cmd_t), .FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo (
    .sys_clk, .mecobo_reset,
    .push(cmd_push), .din(cmd_din), .pop(cmd_pop), .dout(cmd_dout),
    .empty(cmd_empty), .full(cmd_full), .count()
  );

  scheduler scheduler_inst (
    .sys_clk, .mecobo_reset,
    .cmd_dout, .cmd_empty, .cmd_pop, .cmd_bus, .current_time
  );

  // one controller per output pin, unit address is the pin index
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pin
    pin_control #(.POSITION(i)) pin_control_inst (
      .sys_clk, .mecobo_reset, .cmd_bus, .pin(pins[i])
    );
  end

  sample_collector #(.NUM_PINS(NUM_PINS)) sample_collector_inst (
    .sys_clk, .mecobo_reset, .cmd_bus, .pins, .current_time,
    .sample_full, .sample_push, .sample_din
  );

  sync_fifo #(.payload_t(sample_t), .FIFO_DEPTH(FIFO_DEPTH)) sample_fifo (
    .sys_clk, .mecobo_reset,
    .push(sample_push), .din(sample_din), .pop(sample_pop), .dout(sample_dout),
    .empty(sample_empty), .full(sample_full), .count(sample_count)
  );

endmodule

`default_nettype wire

// File: design/mecobo_sample_pkg.sv
`default_nettype none

package mecobo_sample_pkg;

  // one pin reading, stamp is the low part of current_time
  typedef struct packed {
    logic [7:0]  channel;
    logic        value;
    logic [22:0] stamp;
  } sample_t;

  // output behaviour of a pin controller
  typedef enum logic [1:0] {
    mode_off    = 2'd0,
    mode_const  = 2'd1,
    mode_square = 2'd2
  } pin_mode_e;

endpackage

`default_nettype wire

// File: design/pin_control.sv
`timescale 1ns/1ps
`default_nettype none

module pin_control
  import mecobo_cmd_pkg::*, mecobo_sample_pkg::*;
#(
  parameter int POSITION = 0
) (
  input  wire      sys_clk,
  input  wire      mecobo_reset,
  input  cmd_bus_t cmd_bus,
  output logic     pin
);

  pin_mode_e   mode;
  logic [31:0] half_period;
  logic        level;
  logic [31:0] tick;
  logic        sq_state;
  logic        hit;
  logic [31:0] hp_eff;

  assign hit    = cmd_bus.en && (cmd_bus.addr[15:8] == 8'(POSITION));
  // zero would never toggle, run it as one
  assign hp_eff = (half_period == 32'd0) ? 32'd1 : half_period;

  // register file
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      mode        <= mode_off;
      half_period <= 32'd0;
      level       <= 1'b0;
    end else if (hit) begin
      case (cmd_bus.addr[7:0])
        reg_mode:        mode        <= pin_mode_e'(cmd_bus.data[1:0]);
        reg_half_period: half_period <= cmd_bus.data;
        reg_level:       level       <= cmd_bus.data[0];
        default: ;
      endcase
    end
  end

  // square wave, restarts on any write to this pin
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      tick     <= 32'd0;
      sq_state <= 1'b0;
    end else if (hit || mode != mode_square) begin
      tick     <= 32'd0;
      sq_state <= 1'b0;
    end else if (tick >= hp_eff - 32'd1) begin
      tick     <= 32'd0;
      sq_state <= !sq_state;
    end else begin
      tick <= tick + 32'd1;
    end
  end

  always_comb begin
    case (mode)
      mode_const:  pin = level;
      mode_square: pin = sq_state;
      default:     pin = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/sample_collector.sv
`timescale 1ns/1ps
`default_nettype none

module sample_collector
  import mecobo_cmd_pkg::*, mecobo_sample_pkg::*;
#(
  parameter int NUM_PINS = 8
) (
  input  wire                sys_clk,
  input  wire                mecobo_reset,
  input  cmd_bus_t           cmd_bus,
  input  wire [NUM_PINS-1:0] pins,
  input  wire [31:0]         current_time,
  input  wire                sample_full,
  output logic               sample_push,
  output sample_t            sample_din
);

  localparam int IW = (NUM_PINS > 1) ? $clog2(NUM_PINS) : 1;

  logic [NUM_PINS-1:0] channel_mask;
  logic [31:0]         sample_period;
  logic [31:0]         interval_cnt;
  logic                scanning;
  logic [IW-1:0]       scan_idx;
  logic                hit;
  logic                period_tick;

  assign hit         = cmd_bus.en && (cmd_bus.addr[15:8] == collector_unit);
  // period 0 keeps sampling off
  assign period_tick = (sample_period != 32'd0) &&
                       (interval_cnt == sample_period - 32'd1);

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      channel_mask  <= '0;
      sample_period <= 32'd0;
      interval_cnt  <= 32'd0;
    end else begin
      if (hit && cmd_bus.addr[7:0] == reg_channel_mask) begin
        channel_mask <= cmd_bus.data[NUM_PINS-1:0];
      end
      if (hit && cmd_bus.addr[7:0] == reg_sample_period) begin
        sample_period <= cmd_bus.data;
        interval_cnt  <= 32'd0;
      end else if (period_tick) begin
        interval_cnt <= 32'd0;
      end else if (sample_period != 32'd0) begin
        interval_cnt <= interval_cnt + 32'd1;
      end
    end
  end

  // walk all channels, a tick during a scan is skipped
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      scanning <= 1'b0;
      scan_idx <= '0;
    end else if (!scanning) begin
      scanning <= period_tick;
      scan_idx <= '0;
    end else if (scan_idx == IW'(NUM_PINS - 1)) begin
      scanning <= 1'b0;
    end else begin
      scan_idx <= scan_idx + 1'b1;
    end
  end

  // disabled channels and a full FIFO produce nothing
  assign sample_push = scanning && channel_mask[scan_idx] && !sample_full;
  assign sample_din  = '{channel: 8'(scan_idx),
                         value:   pins[scan_idx],
                         stamp:   current_time[22:0]};

endmodule

`default_nettype wire

// File: design/scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module scheduler
  import mecobo_cmd_pkg::*;
(
  input  wire         sys_clk,
  input  wire         mecobo_reset,
  input  cmd_t        cmd_dout,
  input  wire         cmd_empty,
  output logic        cmd_pop,
  output cmd_bus_t    cmd_bus,
  output logic [31:0] current_time
);

  logic due;

  // global time, free running
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      current_time <= 32'd0;
    end else begin
      current_time <= current_time + 32'd1;
    end
  end

  // late commands are due at once
  assign due = !cmd_empty && (cmd_dout.start_time <= current_time);

  // hold off one cycle after each issue so en is a single pulse
  assign cmd_pop = due && !cmd_bus.en;

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      cmd_bus.en <= 1'b0;
    end else begin
      cmd_bus.en <= cmd_pop;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (cmd_pop) begin
      cmd_bus.addr <= cmd_dout.addr;
      cmd_bus.data <= cmd_dout.data;
    end
  end

  a_en_single: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    cmd_bus.en |=> !cmd_bus.en)
    else $error("command bus enable held for two cycles");

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t  = logic [31:0],
  parameter int  FIFO_DEPTH = 16
) (
  input  wire       sys_clk,
  input  wire       mecobo_reset,
  input  wire       push,
  input  payload_t  din,
  input  wire       pop,
  output payload_t  dout,
  output logic      empty,
  output logic      full,
  output logic [7:0] count
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  payload_t        mem [FIFO_DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic            push_ok;
  logic            pop_ok;

  assign empty   = (count == 8'd0);
  assign full    = (count == 8'(FIFO_DEPTH));
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;
  // head is visible without a read cycle
  assign dout    = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 8'd0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + 8'(push_ok) - 8'(pop_ok);
    end
  end

  // occupancy stays within the buffer depth
  a_count_in_range: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    count <= 8'(FIFO_DEPTH))
    else $error("occupancy outside the FIFO depth");

  // the pointers coincide whenever the FIFO is empty or full
  a_ptr_meet: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    (empty || full) |-> (wr_ptr == rd_ptr))
    else $error("pointers disagree with the occupancy count");

endmodule

`default_nettype wire

// File: mecobo.f
design/mecobo_cmd_pkg.sv
design/mecobo_sample_pkg.sv
design/sync_fifo.sv
design/host_bridge.sv
design/scheduler.sv
design/pin_control.sv
design/sample_collector.sv
design/mecobo_core.sv
testbench/mecobo_tb.sv

// File: testbench/mecobo_cases.txt
# op      idx  value     expected   (all fields hex)
# idx is an APB address, pin index or pin mask; value and expected depend on the op
read      0c   ffffffff  00000002
irq       0    0         0
pin       ff   0         00
tdelta    0    19        0
wait      0    10        0
tdelta    0    0         0
sched     3    64        1
late      4    1         1
late      5    1         1
square    6    0         0
square    7    0         0
square    1    0         0
sample    0    a5        40
irq       0    0         0
read      0c   00000002  00000002
read      10   ffffffff  00000000
slverr    0    0         1
write     04   00000102  0
fill      0    0         1
read      0c   00000003  00000003
pin       18   0         18

// File: testbench/mecobo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mecobo_tb
  import mecobo_cmd_pkg::*, mecobo_sample_pkg::*;
();

  localparam int NUM_PINS   = 8;
  localparam int FIFO_DEPTH = 16;

  logic                sys_clk;
  logic                mecobo_reset;
  logic [7:0]          paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic                irq;
  logic [NUM_PINS-1:0] pins;

  logic [31:0] lfsr = 32'h3117;
  logic [31:0] time_base;
  logic        last_slverr;
  int          cycle = 0;
  int          sample_cycle;
  int          limit = 0;
  string       case_op[$];
  logic [31:0] case_arg[$];
  logic [31:0] case_val[$];
  logic [31:0] case_exp[$];

  mecobo_core #(.NUM_PINS(NUM_PINS), .FIFO_DEPTH(FIFO_DEPTH)) mecobo_core_inst (
    .sys_clk, .mecobo_reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
    .irq, .pins
  );

  initial begin
    sys_clk = 1'b0;
    forever #20 sys_clk = ~sys_clk;
  end

  // run limit grows with the number of case lines
  always @(posedge sys_clk) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      $display("timeout: the cases did not finish within %0d cycles", limit);
      $display("tests failed");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] r);
    r = 32'd0;
    repeat (n) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // setup and access cycles with results sampled mid access
  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge sys_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge sys_clk);
    penable <= 1'b1;
    @(negedge sys_clk);
    rdata        = prdata;
    last_slverr  = pslverr;
    sample_cycle = cycle;
    check_equal(32'(pready), 32'd1, "pready in the access cycle");
    @(posedge sys_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic push_cmd(input logic [31:0] start, input logic [7:0] unit,
                          input logic [7:0] rg, input logic [31:0] data);
    logic [31:0] rdata;
    apb_transfer(1'b1, 8'h00, start, rdata);
    apb_transfer(1'b1, 8'h04, {16'd0, unit, rg}, rdata);
    apb_transfer(1'b1, 8'h08, data, rdata);
  endtask

  task automatic read_time(output logic [31:0] t);
    apb_transfer(1'b0, 8'h14, 32'd0, t);
    time_base = t - 32'(sample_cycle);
  endtask

  task automatic wait_time(input logic [31:0] target);
    @(negedge sys_clk);
    while (time_base + 32'(cycle) < target) @(negedge sys_clk);
  endtask

  task automatic wait_irq();
    @(negedge sys_clk);
    while (irq !== 1'b1) @(negedge sys_clk);
  endtask

  task automatic count_to_edge(input int p, output int n);
    logic prev;
    prev = pins[p];
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (pins[p] === prev);
  endtask

  function automatic int next_channel(input logic [31:0] mask, input int ch);
    for (int i = 1; i <= NUM_PINS; i++) begin
      if (mask[(ch + i) % NUM_PINS]) return (ch + i) % NUM_PINS;
    end
    return -1;
  endfunction

  task automatic check_time_step(input int n);
    logic [31:0] t1;
    logic [31:0] t2;
    int          c1;
    read_time(t1);
    c1 = sample_cycle;
    repeat (n) @(posedge sys_clk);
    read_time(t2);
    check_equal(t2 - t1, 32'(sample_cycle - c1), "time step differs from cycles elapsed");
  endtask

  task automatic run_sched(input int p, input logic [31:0] delay, input logic [31:0] level);
    logic [31:0] t0;
    read_time(t0);
    // level lands while the pin is still off
    push_cmd(32'd0, 8'(p), reg_level, level);
    push_cmd(t0 + delay, 8'(p), reg_mode, 32'(mode_const));
    wait_time(t0 + delay / 2);
    check_equal(pins[p], 32'd0, "pin changed before start time");
    wait_time(t0 + delay + 10);
    repeat (20) begin
      check_equal(pins[p], level, "pin level after start time");
      @(negedge sys_clk);
    end
  endtask

  task automatic run_late(input int p, input logic [31:0] level, input logic [31:0] expected);
    int n;
    push_cmd(32'd0, 8'(p), reg_level, level);
    push_cmd(32'd0, 8'(p), reg_mode, 32'(mode_const));
    n = 0;
    @(negedge sys_clk);
    while (pins[p] !== expected[0] && n < 10) begin
      @(negedge sys_clk);
      n++;
    end
    check_equal(pins[p], expected, "late command not applied within 10 cycles");
  endtask

  task automatic run_square(input int p);
    logic [31:0] half;
    int          n;
    take_bits(4, half);
    half = half + 32'd1;
    push_cmd(32'd0, 8'(p), reg_half_period, half);
    push_cmd(32'd0, 8'(p), reg_mode, 32'(mode_square));
    // let the mode write land before locking onto an edge
    repeat (5) @(negedge sys_clk);
    count_to_edge(p, n);
    repeat (3) begin
      count_to_edge(p, n);
      check_equal(32'(n), half, "square wave half period");
    end
  endtask

  task automatic run_sample(input logic [31:0] mask, input logic [31:0] period);
    logic [NUM_PINS-1:0] level;
    logic [31:0]         bits;
    logic [31:0]         data;
    sample_t             smp;
    int                  ch;
    level = '0;
    for (int i = 0; i < NUM_PINS; i++) begin
      if (mask[i]) begin
        take_bits(1, bits);
        level[i] = bits[0];
        push_cmd(32'd0, 8'(i), reg_level, bits);
        push_cmd(32'd0, 8'(i), reg_mode, 32'(mode_const));
      end
    end
    push_cmd(32'd0, collector_unit, reg_channel_mask, mask);
    push_cmd(32'd0, collector_unit, reg_sample_period, period);
    // three scans that each start at the lowest enabled channel
    ch = next_channel(mask, NUM_PINS - 1);
    repeat (3 * $countones(mask)) begin
      wait_irq();
      apb_transfer(1'b0, 8'h10, 32'd0, data);
      smp = data;
      check_equal(last_slverr, 32'd0, "pslverr on a sample pop");
      check_equal(smp.channel, ch, "sample channel order");
      check_equal(smp.value, level[ch], "sample value against pin level");
      ch = next_channel(mask, ch);
    end
    // stop sampling and drain what is left
    push_cmd(32'd0, collector_unit, reg_sample_period, 32'd0);
    repeat (2 * NUM_PINS + 10) @(negedge sys_clk);
    while (irq) begin
      apb_transfer(1'b0, 8'h10, 32'd0, data);
      @(negedge sys_clk);
    end
  endtask

  task automatic run_fill(input logic [31:0] last_err);
    logic [31:0] t0;
    read_time(t0);
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      push_cmd(t0 + 32'h0010_0000, 8'd1, reg_level, 32'd1);
      check_equal(last_slverr, (i == FIFO_DEPTH) ? last_err : 32'd0,
                  "pslverr while filling the command FIFO");
    end
  endtask

  task automatic run_case(input string op, input logic [31:0] a, input logic [31:0] v,
                          input logic [31:0] e);
    logic [31:0] rdata;
    case (op)
      "write": begin
        apb_transfer(1'b1, a[7:0], v, rdata);
        check_equal(last_slverr, e, $sformatf("pslverr on write to %h", a[7:0]));
      end
      "read": begin
        apb_transfer(1'b0, a[7:0], 32'd0, rdata);
        check_equal(rdata & v, e, $sformatf("read of %h", a[7:0]));
      end
      "wait":   repeat (v) @(posedge sys_clk);
      "slverr": check_equal(last_slverr, e, "pslverr of the last transfer");
      "irq": begin
        @(negedge sys_clk);
        check_equal(irq, e, "irq level");
      end
      "pin": begin
        @(negedge sys_clk);
        check_equal(32'(pins) & a, e, "pin levels");
      end
      "tdelta": check_time_step(v);
      "sched":  run_sched(a, v, e);
      "late":   run_late(a, v, e);
      "square": run_square(a);
      "sample": run_sample(v, e);
      "fill":   run_fill(e);
      default: begin
        $display("unknown operation '%s' in the case file", op);
        $display("tests failed");
        $fatal(1, "bad case file");
      end
    endcase
  endtask

  task automatic load_cases();
    int          fd;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] v;
    logic [31:0] e;
    fd = $fopen("testbench/mecobo_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/mecobo_cases.txt");
      $display("tests failed");
      $fatal(1, "missing case file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        // comment and blank lines are skipped
        if (line.len() > 1 && line.substr(0, 0) != "#" &&
            $sscanf(line, "%s %h %h %h", op, a, v, e) == 4) begin
          case_op.push_back(op);
          case_arg.push_back(a);
          case_val.push_back(v);
          case_exp.push_back(e);
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    mecobo_reset = 1'b1;
    paddr        = 8'd0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = 32'd0;
    load_cases();
    limit = 200 * case_op.size() + 2000;
    repeat (4) @(posedge sys_clk);
    mecobo_reset <= 1'b0;
    foreach (case_op[i]) begin
      run_case(case_op[i], case_arg[i], case_val[i], case_exp[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
